/* source/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// Data path and address widths
`define INST_BITS       68
`define OPCODE_BITS     4
`define OFF_ADDR_BITS   32
`define DATA_BITS       128
`define UB_ADDR_BITS    8
`define ACC_ADDR_BITS   6

// Instruction layout: opcode | addr_a | addr_b
`define OPCODE_MSB      67
`define ADDR_A_MSB      63
`define ADDR_B_MSB      31

// Opcode codes
`define OPC_IDLE            4'd0
`define OPC_DATA_FIFO       4'd1
`define OPC_WEIGHT_FIFO     4'd2
`define OPC_UB_TO_DATA_FIFO 4'd3
`define OPC_MAT_MUL         4'd4
`define OPC_MAT_MUL_ACC     4'd5
`define OPC_ACC_TO_UB       4'd6
`define OPC_AXI_TO_UB       4'd7
`define OPC_UB_TO_AXI       4'd8

`endif

/* source/isa_pkg.sv */
`include "ctrl_params.svh"

package isa_pkg;

    // Full instruction word as seen on the input port
    typedef logic [`INST_BITS-1:0] instruction_t;

    // Off-chip address, also the width of both raw address fields
    typedef logic [`OFF_ADDR_BITS-1:0] off_addr_t;

    // Supported opcodes
    typedef enum logic [`OPCODE_BITS-1:0] {
        OP_IDLE            = `OPC_IDLE,
        OP_DATA_FIFO       = `OPC_DATA_FIFO,
        OP_WEIGHT_FIFO     = `OPC_WEIGHT_FIFO,
        OP_UB_TO_DATA_FIFO = `OPC_UB_TO_DATA_FIFO,
        OP_MAT_MUL         = `OPC_MAT_MUL,
        OP_MAT_MUL_ACC     = `OPC_MAT_MUL_ACC,
        OP_ACC_TO_UB       = `OPC_ACC_TO_UB,
        OP_AXI_TO_UB       = `OPC_AXI_TO_UB,
        OP_UB_TO_AXI       = `OPC_UB_TO_AXI
    } opcode_e;

endpackage

/* source/ctrl_pkg.sv */
`include "ctrl_params.svh"

package ctrl_pkg;

    // Phase within a multi-cycle instruction
    typedef enum logic {
        PHASE_FIRST  = 1'b0,
        PHASE_SECOND = 1'b1
    } phase_e;

    // Mode of the off-chip transfer engine
    typedef enum logic [1:0] {
        XFER_IDLE  = 2'b00,
        XFER_LOAD  = 2'b01,
        XFER_STORE = 2'b10
    } xfer_mode_e;

    // On-chip buffer addresses and data words
    typedef logic [`UB_ADDR_BITS-1:0]  ub_addr_t;
    typedef logic [`ACC_ADDR_BITS-1:0] acc_addr_t;
    typedef logic [`DATA_BITS-1:0]     data_t;

endpackage

/* source/inst_fetch.sv */
`include "ctrl_params.svh"

module inst_fetch
    import isa_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         inst_valid,
    input  instruction_t instruction,
    input  logic         inst_ready,
    output logic         accept,
    output opcode_e      opcode,
    output off_addr_t    addr_a,
    output off_addr_t    addr_b
);

    logic [`OPCODE_BITS-1:0] opcode_raw;
    opcode_e                 opcode_dec;

    // Handshake completes when both sides agree
    assign accept = inst_valid && inst_ready;

    assign opcode_raw = instruction[`OPCODE_MSB:`ADDR_A_MSB+1];

    // Codes are contiguous from IDLE, anything past the last one runs as IDLE
    always_comb begin
        if (opcode_raw > `OPC_UB_TO_AXI) begin
            opcode_dec = OP_IDLE;
        end else begin
            opcode_dec = opcode_e'(opcode_raw);
        end
    end

    // Opcode register
    // Falls back to IDLE when the current instruction ends and nothing is offered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opcode <= OP_IDLE;
        end else if (accept) begin
            opcode <= opcode_dec;
        end else if (inst_ready) begin
            opcode <= OP_IDLE;
        end
    end

    // Address fields
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_a <= instruction[`ADDR_A_MSB:`ADDR_B_MSB+1];
            addr_b <= instruction[`ADDR_B_MSB:0];
        end
    end

endmodule

/* source/op_sequencer.sv */
`include "ctrl_params.svh"

module op_sequencer
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    accept,
    input  opcode_e opcode,
    input  logic    xfer_done,
    output phase_e  phase,
    output logic    inst_ready
);

    logic two_phase;

    // Opcodes that own a second phase
    always_comb begin
        case (opcode)
            OP_MAT_MUL,
            OP_MAT_MUL_ACC,
            OP_ACC_TO_UB,
            OP_UB_TO_AXI: two_phase = 1'b1;
            default:      two_phase = 1'b0;
        endcase
    end

    ////////////////////
    // Phase register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PHASE_FIRST;
        end else if (accept) begin
            phase <= PHASE_FIRST;
        end else if (phase == PHASE_FIRST && two_phase) begin
            phase <= PHASE_SECOND;
        end
    end

    ////////////////////
    // Completion
    ////////////////////

    // Ready doubles as the completion flag of the current instruction
    always_comb begin
        case (opcode)
            OP_MAT_MUL,
            OP_MAT_MUL_ACC,
            OP_ACC_TO_UB: begin
                inst_ready = (phase == PHASE_SECOND);
            end
            OP_AXI_TO_UB: begin
                inst_ready = xfer_done;
            end
            OP_UB_TO_AXI: begin
                // Store runs only after the UB read phase
                inst_ready = (phase == PHASE_SECOND) && xfer_done;
            end
            default: begin
                inst_ready = 1'b1;
            end
        endcase
    end

endmodule

/* source/ctrl_decoder.sv */
`include "ctrl_params.svh"

module ctrl_decoder
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  opcode_e    opcode,
    input  phase_e     phase,
    input  logic       xfer_done,
    input  off_addr_t  addr_a,
    input  off_addr_t  addr_b,
    input  data_t      din,
    input  data_t      rin,
    input  data_t      uin,
    output logic       read_ub,
    output logic       write_ub,
    output logic       read_acc,
    output logic       write_acc,
    output logic       data_fifo_en,
    output logic       weight_fifo_en,
    output logic       mm_en,
    output logic       acc_en,
    output logic       xfer_en,
    output xfer_mode_e xfer_mode,
    output ub_addr_t   ub_addr_wr,
    output ub_addr_t   ub_addr_rd,
    output acc_addr_t  acc_addr_wr,
    output acc_addr_t  acc_addr_rd,
    output off_addr_t  offmem_addr_wr,
    output off_addr_t  offmem_addr_rd,
    output data_t      dout
);

    ub_addr_t  ub_wr_field;
    ub_addr_t  ub_rd_field;
    acc_addr_t acc_wr_field;
    acc_addr_t acc_rd_field;

    // Write side from addr_a, read side from addr_b
    assign ub_wr_field  = addr_a[`UB_ADDR_BITS-1:0];
    assign ub_rd_field  = addr_b[`UB_ADDR_BITS-1:0];
    assign acc_wr_field = addr_a[`ACC_ADDR_BITS-1:0];
    assign acc_rd_field = addr_b[`ACC_ADDR_BITS-1:0];

    always_comb begin
        ////////////////////
        // Idle defaults
        ////////////////////
        read_ub        = 1'b0;
        write_ub       = 1'b0;
        read_acc       = 1'b0;
        write_acc      = 1'b0;
        data_fifo_en   = 1'b0;
        weight_fifo_en = 1'b0;
        mm_en          = 1'b0;
        acc_en         = 1'b0;
        xfer_en        = 1'b0;
        xfer_mode      = XFER_IDLE;
        ub_addr_wr     = '0;
        ub_addr_rd     = '0;
        acc_addr_wr    = '0;
        acc_addr_rd    = '0;
        offmem_addr_wr = '0;
        offmem_addr_rd = '0;
        dout           = '0;

        ////////////////////
        // Per-opcode overrides
        ////////////////////
        case (opcode)
            OP_DATA_FIFO: begin
                data_fifo_en = 1'b1;
            end
            OP_WEIGHT_FIFO: begin
                weight_fifo_en = 1'b1;
            end
            OP_UB_TO_DATA_FIFO: begin
                read_ub      = 1'b1;
                data_fifo_en = 1'b1;
                ub_addr_rd   = ub_rd_field;
            end
            OP_MAT_MUL,
            OP_MAT_MUL_ACC: begin
                // Accumulate mode holds acc_en over both phases
                acc_en = (opcode == OP_MAT_MUL_ACC);
                if (phase == PHASE_FIRST) begin
                    read_ub    = 1'b1;
                    ub_addr_rd = ub_rd_field;
                end else begin
                    write_acc    = 1'b1;
                    mm_en        = 1'b1;
                    data_fifo_en = 1'b1;
                    acc_addr_wr  = acc_wr_field;
                end
            end
            OP_ACC_TO_UB: begin
                if (phase == PHASE_FIRST) begin
                    read_acc    = 1'b1;
                    acc_addr_rd = acc_rd_field;
                end else begin
                    write_ub   = 1'b1;
                    ub_addr_wr = ub_wr_field;
                    dout       = rin;
                end
            end
            OP_AXI_TO_UB: begin
                if (!xfer_done) begin
                    xfer_en        = 1'b1;
                    xfer_mode      = XFER_LOAD;
                    offmem_addr_rd = addr_b;
                end else begin
                    // Loaded word lands in the UB on the done cycle
                    write_ub   = 1'b1;
                    ub_addr_wr = ub_wr_field;
                    dout       = din;
                end
            end
            OP_UB_TO_AXI: begin
                if (phase == PHASE_FIRST) begin
                    read_ub    = 1'b1;
                    ub_addr_rd = ub_rd_field;
                end else if (!xfer_done) begin
                    xfer_en        = 1'b1;
                    xfer_mode      = XFER_STORE;
                    offmem_addr_wr = addr_a;
                    dout           = uin;
                end
                // Done cycle keeps the defaults
            end
            default: begin
                // IDLE keeps the defaults
            end
        endcase
    end

endmodule

/* source/ctrl_unit_top.sv */
`include "ctrl_params.svh"

module ctrl_unit_top
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         inst_valid,
    input  instruction_t instruction,
    output logic         inst_ready,
    input  logic         xfer_done,
    input  data_t        din,
    input  data_t        rin,
    input  data_t        uin,
    output logic         read_ub,
    output logic         write_ub,
    output logic         read_acc,
    output logic         write_acc,
    output logic         data_fifo_en,
    output logic         weight_fifo_en,
    output logic         mm_en,
    output logic         acc_en,
    output logic         xfer_en,
    output xfer_mode_e   xfer_mode,
    output ub_addr_t     ub_addr_wr,
    output ub_addr_t     ub_addr_rd,
    output acc_addr_t    acc_addr_wr,
    output acc_addr_t    acc_addr_rd,
    output off_addr_t    offmem_addr_wr,
    output off_addr_t    offmem_addr_rd,
    output data_t        dout
);

    logic      accept;
    opcode_e   opcode;
    off_addr_t addr_a;
    off_addr_t addr_b;
    phase_e    phase;

    ////////////////////
    // Fetch
    ////////////////////

    inst_fetch i_inst_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .instruction (instruction),
        .inst_ready  (inst_ready),
        .accept      (accept),
        .opcode      (opcode),
        .addr_a      (addr_a),
        .addr_b      (addr_b)
    );

    ////////////////////
    // Sequencing
    ////////////////////

    op_sequencer i_op_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (accept),
        .opcode     (opcode),
        .xfer_done  (xfer_done),
        .phase      (phase),
        .inst_ready (inst_ready)
    );

    ////////////////////
    // Output decode
    ////////////////////

    ctrl_decoder i_ctrl_decoder (
        .opcode         (opcode),
        .phase          (phase),
        .xfer_done      (xfer_done),
        .addr_a         (addr_a),
        .addr_b         (addr_b),
        .din            (din),
        .rin            (rin),
        .uin            (uin),
        .read_ub        (read_ub),
        .write_ub       (write_ub),
        .read_acc       (read_acc),
        .write_acc      (write_acc),
        .data_fifo_en   (data_fifo_en),
        .weight_fifo_en (weight_fifo_en),
        .mm_en          (mm_en),
        .acc_en         (acc_en),
        .xfer_en        (xfer_en),
        .xfer_mode      (xfer_mode),
        .ub_addr_wr     (ub_addr_wr),
        .ub_addr_rd     (ub_addr_rd),
        .acc_addr_wr    (acc_addr_wr),
        .acc_addr_rd    (acc_addr_rd),
        .offmem_addr_wr (offmem_addr_wr),
        .offmem_addr_rd (offmem_addr_rd),
        .dout           (dout)
    );

endmodule

/* testbench/ctrl_unit_chk.sv */
`include "ctrl_params.svh"

module ctrl_unit_chk
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         inst_valid,
    input instruction_t instruction,
    input logic         inst_ready,
    input logic         xfer_done,
    input data_t        din,
    input data_t        rin,
    input data_t        uin,
    input logic         read_ub, write_ub, read_acc, write_acc,
    input logic         data_fifo_en, weight_fifo_en, mm_en, acc_en, xfer_en,
    input xfer_mode_e   xfer_mode,
    input ub_addr_t     ub_addr_wr, ub_addr_rd,
    input acc_addr_t    acc_addr_wr, acc_addr_rd,
    input off_addr_t    offmem_addr_wr, offmem_addr_rd,
    input data_t        dout
);

    // One bit per strobe, same order as the en vector
    localparam logic [8:0] RD_UB  = 9'h100;
    localparam logic [8:0] WR_UB  = 9'h080;
    localparam logic [8:0] RD_ACC = 9'h040;
    localparam logic [8:0] WR_ACC = 9'h020;
    localparam logic [8:0] DFIFO  = 9'h010;
    localparam logic [8:0] WFIFO  = 9'h008;
    localparam logic [8:0] MM     = 9'h004;
    localparam logic [8:0] ACC    = 9'h002;
    localparam logic [8:0] XFER   = 9'h001;

    logic [8:0]              en;
    logic [`OPCODE_BITS-1:0] code_in;
    logic                    out_of_reset;
    opcode_e                 sh_op;
    off_addr_t               sh_a;
    off_addr_t               sh_b;
    int                      cyc;
    logic                    is_mm;
    logic [8:0]              acc_bit;
    int                      error_count = 0;

    assign en = {read_ub, write_ub, read_acc, write_acc, data_fifo_en,
                 weight_fifo_en, mm_en, acc_en, xfer_en};
    assign code_in = instruction[`OPCODE_MSB:`ADDR_A_MSB+1];
    assign is_mm   = (sh_op == OP_MAT_MUL) || (sh_op == OP_MAT_MUL_ACC);
    assign acc_bit = (sh_op == OP_MAT_MUL_ACC) ? ACC : 9'h000;

    task automatic count_error(string what);
        $error("Checker: %s", what);
        error_count++;
    endtask

    ////////////////////
    // Shadow state
    ////////////////////

    // Low during reset and until the first edge after it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    // Last accepted instruction and cycle count within it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sh_op <= OP_IDLE;
            sh_a  <= '0;
            sh_b  <= '0;
            cyc   <= 0;
        end else if (inst_valid && inst_ready) begin
            // Undefined codes run as IDLE
            sh_op <= (code_in > `OPC_UB_TO_AXI) ? OP_IDLE : opcode_e'(code_in);
            sh_a  <= instruction[`ADDR_A_MSB:`ADDR_B_MSB+1];
            sh_b  <= instruction[`ADDR_B_MSB:0];
            cyc   <= 0;
        end else if (inst_ready) begin
            sh_op <= OP_IDLE;
            cyc   <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    ////////////////////
    // Assertions
    ////////////////////

    property holds(bit cond, bit check);
        @(posedge clk) disable iff (!rst_n) cond |-> check;
    endproperty

    a_reset: assert property (@(posedge clk) !out_of_reset |-> en == '0 && inst_ready)
        else count_error("outputs not idle around reset");
    a_idle: assert property (holds(sh_op == OP_IDLE,
        en == '0 && xfer_mode == XFER_IDLE && inst_ready)) else count_error("IDLE cycle");
    a_dfifo: assert property (holds(sh_op == OP_DATA_FIFO, en == DFIFO && inst_ready))
        else count_error("DATA_FIFO cycle");
    a_wfifo: assert property (holds(sh_op == OP_WEIGHT_FIFO, en == WFIFO && inst_ready))
        else count_error("WEIGHT_FIFO cycle");
    a_ub_dfifo: assert property (holds(sh_op == OP_UB_TO_DATA_FIFO, en == (RD_UB | DFIFO)
        && ub_addr_rd == sh_b[7:0] && inst_ready)) else count_error("UB_TO_DATA_FIFO cycle");

    // Matrix multiply, with or without accumulation
    a_mm_first: assert property (holds(is_mm && cyc == 0, en == (RD_UB | acc_bit)
        && ub_addr_rd == sh_b[7:0] && !inst_ready)) else count_error("MAT_MUL first cycle");
    a_mm_second: assert property (holds(is_mm && cyc == 1,
        en == (WR_ACC | MM | DFIFO | acc_bit) && acc_addr_wr == sh_a[5:0] && inst_ready))
        else count_error("MAT_MUL second cycle");

    a_acc_first: assert property (holds(sh_op == OP_ACC_TO_UB && cyc == 0, en == RD_ACC
        && acc_addr_rd == sh_b[5:0] && !inst_ready)) else count_error("ACC_TO_UB first cycle");
    a_acc_second: assert property (holds(sh_op == OP_ACC_TO_UB && cyc == 1, en == WR_UB
        && ub_addr_wr == sh_a[7:0] && dout == rin && inst_ready))
        else count_error("ACC_TO_UB second cycle");

    // Off-chip load
    a_load_busy: assert property (holds(sh_op == OP_AXI_TO_UB && !xfer_done, en == XFER
        && xfer_mode == XFER_LOAD && offmem_addr_rd == sh_b && !inst_ready))
        else count_error("AXI_TO_UB transfer cycle");
    a_load_done: assert property (holds(sh_op == OP_AXI_TO_UB && xfer_done,
        en == WR_UB && dout == din && inst_ready)) else count_error("AXI_TO_UB done cycle");

    // Off-chip store
    a_store_read: assert property (holds(sh_op == OP_UB_TO_AXI && cyc == 0, en == RD_UB
        && ub_addr_rd == sh_b[7:0] && !inst_ready)) else count_error("UB_TO_AXI read cycle");
    a_store_busy: assert property (holds(sh_op == OP_UB_TO_AXI && cyc > 0 && !xfer_done,
        en == XFER && xfer_mode == XFER_STORE && offmem_addr_wr == sh_a && dout == uin
        && !inst_ready)) else count_error("UB_TO_AXI transfer cycle");
    a_store_done: assert property (holds(sh_op == OP_UB_TO_AXI && cyc > 0 && xfer_done,
        en == '0 && inst_ready)) else count_error("UB_TO_AXI done cycle");

endmodule

bind ctrl_unit_top ctrl_unit_chk i_ctrl_unit_chk (.*);

/* testbench/ctrl_unit_tb.sv */
`include "ctrl_params.svh"

module ctrl_unit_tb
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    localparam int NUM_OPS         = 9;
    localparam int RUNS_PER_OP     = 6;
    // Generous count of instructions needed to cover every opcode
    localparam int INST_BUDGET     = 4 * NUM_OPS * RUNS_PER_OP;
    localparam int WATCHDOG_CYCLES = 20 * INST_BUDGET + 200;

    logic         clk;
    logic         rst_n;
    logic         inst_valid;
    instruction_t instruction;
    logic         inst_ready;
    logic         xfer_done;
    data_t        din;
    data_t        rin;
    data_t        uin;
    logic         read_ub, write_ub, read_acc, write_acc;
    logic         data_fifo_en, weight_fifo_en, mm_en, acc_en, xfer_en;
    xfer_mode_e   xfer_mode;
    ub_addr_t     ub_addr_wr, ub_addr_rd;
    acc_addr_t    acc_addr_wr, acc_addr_rd;
    off_addr_t    offmem_addr_wr, offmem_addr_rd;
    data_t        dout;

    integer seed;
    int     runs [NUM_OPS];
    int     xfer_wait;
    logic   all_ran;

    ctrl_unit_top i_ctrl_unit_top (.*);

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic data_t rand_word();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic instruction_t next_instruction();
        logic [`OPCODE_BITS-1:0] code;
        int                      pick;
        pick = rand_below(NUM_OPS + 1);
        // Extra pick stands for an undefined code
        if (pick == NUM_OPS) begin
            code = 4'(9 + rand_below(7));
        end else begin
            code = 4'(pick);
        end
        return {code, off_addr_t'($random(seed)), off_addr_t'($random(seed))};
    endfunction

    function automatic logic every_op_ran();
        foreach (runs[i]) begin
            if (runs[i] < RUNS_PER_OP) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////
    // Stimulus
    //////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            if (inst_valid && inst_ready && instruction[`OPCODE_MSB:`ADDR_A_MSB+1] < NUM_OPS) begin
                runs[instruction[`OPCODE_MSB:`ADDR_A_MSB+1]]++;
            end
            // Offer stays put until taken, gaps of random length in between
            if (!inst_valid || inst_ready) begin
                inst_valid  <= (rand_below(4) != 0);
                instruction <= next_instruction();
            end
            // Transfer engine answers after 1 to 5 cycles of xfer_en
            if (xfer_done) begin
                xfer_done <= 1'b0;
            end else if (xfer_en) begin
                if (xfer_wait == 0) begin
                    xfer_wait = 1 + rand_below(5);
                end
                xfer_wait = xfer_wait - 1;
                if (xfer_wait == 0) begin
                    xfer_done <= 1'b1;
                end
            end
            din     <= rand_word();
            rin     <= rand_word();
            uin     <= rand_word();
            all_ran <= every_op_ran();
        end
    end

    initial begin
        seed        = 32'h5672;
        rst_n       = 1'b0;
        inst_valid  = 1'b0;
        instruction = '0;
        xfer_done   = 1'b0;
        din         = '0;
        rin         = '0;
        uin         = '0;
        xfer_wait   = 0;
        all_ran     = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait (all_ran);
        repeat (10) @(posedge clk);
        if (i_ctrl_unit_top.i_ctrl_unit_chk.error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "checker reported errors");
        end
    end

    // Stop at the first assertion failure
    initial begin
        wait (i_ctrl_unit_top.i_ctrl_unit_chk.error_count != 0);
        $display("FAIL at time %0t: checker assertion failed", $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: instruction stream did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* sources.f */
+incdir+source
source/isa_pkg.sv
source/ctrl_pkg.sv
source/inst_fetch.sv
source/op_sequencer.sv
source/ctrl_decoder.sv
source/ctrl_unit_top.sv
testbench/ctrl_unit_chk.sv
testbench/ctrl_unit_tb.sv
